// File: z3_bus_pkg.sv
// Zorro III bus types: cycle FSM states, memory space codes and data word lanes
`default_nettype none

package z3_bus_pkg;

	// --------------------------------------------------
	// slave cycle FSM states
	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_MATCH     = 3'd1,
		ST_DATA      = 3'd2,
		ST_MEM_WAIT  = 3'd3,
		ST_ACK_DELAY = 3'd4,
		ST_DTACK     = 3'd5
	} z3_state_e;

	// --------------------------------------------------
	// memory space code, FC1..FC0
	typedef logic [1:0] z3_fc_t;

	localparam z3_fc_t FC_DATA = 2'b01;
	localparam z3_fc_t FC_PROG = 2'b10;

	// only data and program space are answered
	// cpu space and reserved codes have equal bits
	function automatic logic space_is_data_prog(z3_fc_t fc);
		return fc inside {FC_DATA, FC_PROG};
	endfunction

	// --------------------------------------------------
	// data word in pin order: AD31..24, SD7..0, AD23..8
	typedef struct packed {
		logic [7:0]  ad_hi;
		logic [7:0]  sd;
		logic [15:0] ad_lo;
	} z3_lanes_t;

	// byte 3 belongs to nDS3, byte 0 to nDS0
	typedef union packed {
		z3_lanes_t       lanes;
		logic [3:0][7:0] bytes;
	} z3_data_u;

endpackage

`default_nettype wire

// File: z3_card_pkg.sv
// Zorro III card identity: autoconfig ROM contents, register numbers, config space
`default_nettype none

package z3_card_pkg;

	// A31..A16 of configuration space
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;

	// --------------------------------------------------
	// register number is {A8, A4..A2}
	// A8 picks the low nibble of a register
	// base address write at offset 0x44
	localparam logic [3:0] REG_BASE   = 4'd1;
	// shut-up write at offset 0x4c
	localparam logic [3:0] REG_SHUTUP = 4'd3;

	// --------------------------------------------------
	// nibbles as driven on D31..D28
	// everything past er_Type is stored inverted
	// 0..7 high nibbles of offsets 0x00..0x1c, 8..15 low nibbles
	localparam logic [3:0] cfg_rom [16] = '{
		// type 0x82: zorro III, 64 MB, not in memory list
		4'h8,
		// product, flags, reserved, manufacturer, serial
		4'hB, 4'hC, 4'hF, 4'hE, 4'hC, 4'hF, 4'hF,
		4'h2,
		4'hD, 4'hF, 4'hF, 4'hD, 4'hB, 4'hF, 4'hE
	};

endpackage

`default_nettype wire

// File: z3_bus_frontend.sv
// Zorro III bus front end: samples pins, latches address at FCS fall, decodes hits
`default_nettype none

module z3_bus_frontend (
	input  logic                 clk,
	input  logic                 nIORST,
	input  logic                 nfcs_i,
	input  logic                 doe_i,
	input  logic                 read_i,
	input  z3_bus_pkg::z3_fc_t   fc_i,
	input  logic [3:0]           nds_i,
	input  logic [23:0]          ad_i,
	input  logic [5:0]           a_lo_i,
	input  logic [7:0]           sd_i,
	input  logic [15:0]          base_i,
	input  logic                 cfg_active_i,
	output logic                 cyc_start_o,
	output logic                 nfcs_q_o,
	output logic                 doe_q_o,
	output logic [3:0]           nds_q_o,
	output logic                 read_o,
	output logic [31:0]          addr_o,
	output z3_bus_pkg::z3_data_u wdata_o,
	output logic                 cfg_hit_o,
	output logic                 mem_hit_o
);
	import z3_bus_pkg::*;
	import z3_card_pkg::*;

	logic fcs_fall;
	logic space_ok;
	logic cfg_match;
	logic mem_match;

	// first sample of nFCS low after high
	assign fcs_fall = nfcs_q_o & ~nfcs_i;
	assign space_ok = space_is_data_prog(fc_i);

	// config space only while waiting for a base
	assign cfg_match = (ad_i[23:8] == CFG_SPACE_HI) & cfg_active_i & space_ok;
	// 64 MB window, base of zero means not yet placed
	assign mem_match = (ad_i[23:18] == base_i[15:10]) & (base_i != '0) & space_ok;

	// --------------------------------------------------
	// strobes and cycle start
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			nfcs_q_o    <= 1'b1;
			doe_q_o     <= 1'b0;
			nds_q_o     <= 4'hF;
			cyc_start_o <= 1'b0;
			cfg_hit_o   <= 1'b0;
			mem_hit_o   <= 1'b0;
		end else begin
			nfcs_q_o    <= nfcs_i;
			doe_q_o     <= doe_i;
			nds_q_o     <= nds_i;
			cyc_start_o <= fcs_fall;
			// hits held for the whole cycle
			if (fcs_fall) begin
				cfg_hit_o <= cfg_match;
				mem_hit_o <= mem_match;
			end
		end
	end

	// --------------------------------------------------
	// address phase latch, AD goes away right after FCS
	always_ff @(posedge clk) begin
		if (fcs_fall) begin
			addr_o <= {ad_i, a_lo_i, 2'b00};
			read_o <= read_i;
		end
	end

	// write data, sampled every clock alongside nDS
	always_ff @(posedge clk) begin
		wdata_o.lanes.ad_hi <= ad_i[23:16];
		wdata_o.lanes.sd    <= sd_i;
		wdata_o.lanes.ad_lo <= ad_i[15:0];
	end

endmodule

`default_nettype wire

// File: z3_cycle_fsm.sv
// Zorro III slave cycle FSM: select, data phase, memory requests and DTACK timing
`default_nettype none

module z3_cycle_fsm #(
	parameter int MEM_ADDR_W = 8,
	parameter int ACK_DELAY  = 3
) (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   cyc_start_i,
	input  logic                   nfcs_q_i,
	input  logic                   doe_q_i,
	input  logic [3:0]             nds_q_i,
	input  logic                   read_i,
	input  logic [31:0]            addr_i,
	input  z3_bus_pkg::z3_data_u   wdata_i,
	input  logic                   cfg_hit_i,
	input  logic                   mem_hit_i,
	input  logic [3:0]             cfg_rdata_i,
	input  logic                   mem_req_ready_i,
	input  logic                   mem_rsp_valid_i,
	input  logic [31:0]            mem_rsp_data_i,
	output logic                   mem_req_valid_o,
	output logic                   mem_we_o,
	output logic [3:0]             mem_be_o,
	output logic [MEM_ADDR_W-1:0]  mem_addr_o,
	output z3_bus_pkg::z3_data_u   mem_wdata_o,
	output logic                   cfg_we_o,
	output logic [15:0]            cfg_wdata_o,
	output logic [23:0]            ad_o,
	output logic [7:0]             sd_o,
	output logic                   data_oe_o,
	output logic                   nslaven_o,
	output logic                   ndtack_o,
	output logic                   ndtack_oe_o
);
	import z3_bus_pkg::*;

	localparam int CNT_W = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;

	z3_state_e        state_q;
	z3_state_e        state_d;
	logic             is_cfg_q;
	logic [CNT_W-1:0] ack_cnt_q;
	z3_data_u         rdata_q;
	logic             data_go;
	logic             mem_xfer;

	// reads go on DOE, writes wait for a data strobe too
	assign data_go  = doe_q_i & (read_i | (nds_q_i != 4'hF));
	assign mem_xfer = mem_req_valid_o & mem_req_ready_i;

	// --------------------------------------------------
	// next state, master negating FCS always ends the cycle
	always_comb begin
		state_d = state_q;
		if (nfcs_q_i) begin
			state_d = ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE:      if (cyc_start_i && (cfg_hit_i || mem_hit_i)) state_d = ST_MATCH;
				ST_MATCH:     if (data_go) state_d = ST_DATA;
				ST_DATA:      state_d = is_cfg_q ? ST_ACK_DELAY : ST_MEM_WAIT;
				// read done on response, write done on handshake
				ST_MEM_WAIT:  if (read_i ? mem_rsp_valid_i : mem_xfer) state_d = ST_ACK_DELAY;
				ST_ACK_DELAY: if (ack_cnt_q == CNT_W'(ACK_DELAY - 1)) state_d = ST_DTACK;
				ST_DTACK:     state_d = ST_DTACK;
				default:      state_d = ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// state, counters and registered bus outputs
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q         <= ST_IDLE;
			is_cfg_q        <= 1'b0;
			ack_cnt_q       <= '0;
			mem_req_valid_o <= 1'b0;
			cfg_we_o        <= 1'b0;
			nslaven_o       <= 1'b1;
			ndtack_o        <= 1'b1;
			ndtack_oe_o     <= 1'b0;
			data_oe_o       <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_IDLE && cyc_start_i)
				is_cfg_q <= cfg_hit_i;
			ack_cnt_q <= (state_q == ST_ACK_DELAY) ? ack_cnt_q + 1'b1 : '0;
			// request raised once, dropped on the accepting edge
			if (state_q == ST_DATA && state_d == ST_MEM_WAIT)
				mem_req_valid_o <= 1'b1;
			else if (mem_xfer || state_d == ST_IDLE)
				mem_req_valid_o <= 1'b0;
			// single pulse into the autoconfig registers
			cfg_we_o  <= (state_q == ST_DATA) && (state_d == ST_ACK_DELAY) && !read_i;
			nslaven_o <= (state_d == ST_IDLE);
			ndtack_o  <= (state_d != ST_DTACK);
			// DTACK driven high during the cycle, released one clock late
			ndtack_oe_o <= (state_d != ST_IDLE) || (state_q != ST_IDLE);
			data_oe_o   <= (state_d != ST_IDLE) && doe_q_i && read_i;
		end
	end

	// --------------------------------------------------
	// request fields, fixed while valid is up
	always_ff @(posedge clk) begin
		if (state_q == ST_DATA) begin
			mem_addr_o  <= addr_i[MEM_ADDR_W+1:2];
			mem_we_o    <= !read_i;
			mem_be_o    <= nds_q_i;
			mem_wdata_o <= wdata_i;
			cfg_wdata_o <= {wdata_i.lanes.ad_hi, wdata_i.lanes.sd};
		end
	end

	// read data, config nibble on D31..D28 with ones below
	always_ff @(posedge clk) begin
		if (state_q == ST_DATA && is_cfg_q)
			rdata_q <= {cfg_rdata_i, 28'hFFF_FFFF};
		else if (state_q == ST_MEM_WAIT && mem_rsp_valid_i)
			rdata_q <= mem_rsp_data_i;
	end

	// back onto the pins in lane order
	assign ad_o = {rdata_q.lanes.ad_hi, rdata_q.lanes.ad_lo};
	assign sd_o = rdata_q.lanes.sd;

endmodule

`default_nettype wire

// File: z3_autoconfig.sv
// Zorro III autoconfig: ROM reads, base and shut-up registers, config chain
`default_nettype none

module z3_autoconfig (
	input  logic        clk,
	input  logic        nIORST,
	input  logic [3:0]  reg_num_i,
	input  logic        we_i,
	input  logic [15:0] wdata_i,
	input  logic        ncfgin_i,
	input  logic        sensez3_i,
	output logic [3:0]  rdata_o,
	output logic [15:0] base_o,
	output logic        cfg_active_o,
	output logic        ncfgout_o
);
	import z3_card_pkg::*;

	logic ncfgin_q;
	logic sense_q;
	logic configured_q;
	logic shutup_q;

	// --------------------------------------------------
	// chain inputs sampled on clk like every bus pin
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			ncfgin_q <= 1'b1;
			sense_q  <= 1'b1;
		end else begin
			ncfgin_q <= ncfgin_i;
			sense_q  <= sensez3_i;
		end
	end

	// --------------------------------------------------
	// register writes, base is A31..A16 of the window
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_o       <= '0;
			configured_q <= 1'b0;
			shutup_q     <= 1'b0;
		end else if (we_i && sense_q) begin
			case (reg_num_i)
				REG_BASE: begin
					base_o       <= wdata_i;
					configured_q <= 1'b1;
				end
				REG_SHUTUP: shutup_q <= 1'b1;
				default: ;
			endcase
		end
	end

	// nibble ROM, read combinationally
	assign rdata_o = cfg_rom[reg_num_i];

	// answer config space only while it is our turn in the chain
	assign cfg_active_o = sense_q & ~ncfgin_q & ~configured_q & ~shutup_q;

	// zorro II backplane: stay quiet and pass the chain through
	assign ncfgout_o = sense_q ? ~(configured_q | shutup_q) : ncfgin_q;

endmodule

`default_nettype wire

// File: z3_mem_window.sv
// on-chip word RAM with active-low byte strobes behind a valid/ready port
`default_nettype none

module z3_mem_window #(
	parameter int MEM_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  nIORST,
	input  logic                  req_valid_i,
	input  logic                  req_we_i,
	input  logic [3:0]            req_be_i,
	input  logic [MEM_ADDR_W-1:0] req_addr_i,
	input  z3_bus_pkg::z3_data_u  req_wdata_i,
	output logic                  req_ready_o,
	output logic                  rsp_valid_o,
	output logic [31:0]           rsp_data_o
);
	localparam int MEM_READ_LAT = 2;
	localparam int DEPTH        = 1 << MEM_ADDR_W;
	localparam int LAT_W        = $clog2(MEM_READ_LAT + 1);

	// word address only, so bus addresses wrap on the RAM size
	logic [3:0][7:0]  ram [DEPTH];
	logic [LAT_W-1:0] lat_q;
	logic             accept;

	// busy while a read is in flight
	assign req_ready_o = (lat_q == '0);
	assign accept      = req_valid_i & req_ready_o;

	// --------------------------------------------------
	// array access, bytes with nDS low are written
	always_ff @(posedge clk) begin
		if (accept) begin
			if (req_we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (!req_be_i[b])
						ram[req_addr_i][b] <= req_wdata_i.bytes[b];
				end
			end else begin
				rsp_data_o <= ram[req_addr_i];
			end
		end
	end

	// --------------------------------------------------
	// read latency, response on the last count
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			lat_q       <= '0;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= (lat_q == LAT_W'(1));
			if (accept && !req_we_i)
				lat_q <= LAT_W'(MEM_READ_LAT);
			else if (lat_q != '0)
				lat_q <= lat_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: z3_slave_top.sv
// Zorro III memory card slave: front end, cycle FSM, autoconfig and RAM window
`default_nettype none

module z3_slave_top #(
	parameter int MEM_ADDR_W = 8,
	parameter int ACK_DELAY  = 3
) (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        nfcs_i,
	input  logic        doe_i,
	input  logic        read_i,
	input  logic [1:0]  fc_i,
	input  logic [3:0]  nds_i,
	input  logic [23:0] ad_i,
	input  logic [5:0]  a_lo_i,
	input  logic [7:0]  sd_i,
	input  logic        ncfgin_i,
	input  logic        sensez3_i,
	output logic [23:0] ad_o,
	output logic [7:0]  sd_o,
	output logic        data_oe_o,
	output logic        nslaven_o,
	output logic        ndtack_o,
	output logic        ndtack_oe_o,
	output logic        ncfgout_o
);
	import z3_bus_pkg::*;

	// front end to FSM
	logic                  fe_cyc_start;
	logic                  fe_nfcs_q;
	logic                  fe_doe_q;
	logic [3:0]            fe_nds_q;
	logic                  fe_read;
	logic [31:0]           fe_addr;
	z3_data_u              fe_wdata;
	logic                  fe_cfg_hit;
	logic                  fe_mem_hit;
	// autoconfig
	logic [15:0]           ac_base;
	logic                  ac_cfg_active;
	logic [3:0]            ac_rdata;
	logic                  cfg_we;
	logic [15:0]           cfg_wdata;
	// memory request and response
	logic                  mem_req_valid;
	logic                  mem_req_ready;
	logic                  mem_we;
	logic [3:0]            mem_be;
	logic [MEM_ADDR_W-1:0] mem_addr;
	z3_data_u              mem_wdata;
	logic                  mem_rsp_valid;
	logic [31:0]           mem_rsp_data;

	// --------------------------------------------------
	z3_bus_frontend u_frontend (
		.clk (clk), .nIORST (nIORST),
		.nfcs_i (nfcs_i), .doe_i (doe_i), .read_i (read_i), .fc_i (fc_i),
		.nds_i (nds_i), .ad_i (ad_i), .a_lo_i (a_lo_i), .sd_i (sd_i),
		.base_i (ac_base), .cfg_active_i (ac_cfg_active),
		.cyc_start_o (fe_cyc_start), .nfcs_q_o (fe_nfcs_q), .doe_q_o (fe_doe_q),
		.nds_q_o (fe_nds_q), .read_o (fe_read), .addr_o (fe_addr),
		.wdata_o (fe_wdata), .cfg_hit_o (fe_cfg_hit), .mem_hit_o (fe_mem_hit)
	);

	z3_cycle_fsm #(.MEM_ADDR_W (MEM_ADDR_W), .ACK_DELAY (ACK_DELAY)) u_fsm (
		.clk (clk), .nIORST (nIORST),
		.cyc_start_i (fe_cyc_start), .nfcs_q_i (fe_nfcs_q), .doe_q_i (fe_doe_q),
		.nds_q_i (fe_nds_q), .read_i (fe_read), .addr_i (fe_addr),
		.wdata_i (fe_wdata), .cfg_hit_i (fe_cfg_hit), .mem_hit_i (fe_mem_hit),
		.cfg_rdata_i (ac_rdata), .mem_req_ready_i (mem_req_ready),
		.mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_data_i (mem_rsp_data),
		.mem_req_valid_o (mem_req_valid), .mem_we_o (mem_we), .mem_be_o (mem_be),
		.mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata),
		.cfg_we_o (cfg_we), .cfg_wdata_o (cfg_wdata),
		.ad_o (ad_o), .sd_o (sd_o), .data_oe_o (data_oe_o), .nslaven_o (nslaven_o),
		.ndtack_o (ndtack_o), .ndtack_oe_o (ndtack_oe_o)
	);

	// register number is {A8, A4..A2}
	z3_autoconfig u_autoconfig (
		.clk (clk), .nIORST (nIORST),
		.reg_num_i ({fe_addr[8], fe_addr[4:2]}), .we_i (cfg_we), .wdata_i (cfg_wdata),
		.ncfgin_i (ncfgin_i), .sensez3_i (sensez3_i),
		.rdata_o (ac_rdata), .base_o (ac_base), .cfg_active_o (ac_cfg_active),
		.ncfgout_o (ncfgout_o)
	);

	z3_mem_window #(.MEM_ADDR_W (MEM_ADDR_W)) u_mem (
		.clk (clk), .nIORST (nIORST),
		.req_valid_i (mem_req_valid), .req_we_i (mem_we), .req_be_i (mem_be),
		.req_addr_i (mem_addr), .req_wdata_i (mem_wdata),
		.req_ready_o (mem_req_ready), .rsp_valid_o (mem_rsp_valid),
		.rsp_data_o (mem_rsp_data)
	);

endmodule

`default_nettype wire

// File: tb_z3_slave_assertions.sv
// protocol assertions on the Zorro III slave pins, bound into the top level
`default_nettype none

module tb_z3_slave_assertions (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic doe_i,
	input logic read_i,
	input logic nslaven_o,
	input logic ndtack_o,
	input logic data_oe_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// --------------------------------------------------
	// DTACK only inside a selected cycle
	a_dtack_selected: assert property (@(posedge clk) disable iff (!nIORST)
		!ndtack_o |-> !nslaven_o)
		else $error("ndtack_o low while nslaven_o is high");

	// pins reach data_oe_o through two register stages
	a_oe_on_read: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_o |-> ($past(read_i, 2) && $past(doe_i, 2)))
		else $error("data_oe_o high without read_i and doe_i");

	// DTACK is released only after the master drops FCS
	a_dtack_held: assert property (@(posedge clk) disable iff (!nIORST)
		$rose(ndtack_o) |-> $past(nfcs_i, 2))
		else $error("ndtack_o released while nfcs_i still low");

endmodule

bind z3_slave_top tb_z3_slave_assertions u_assertions (
	.clk (clk), .nIORST (nIORST),
	.nfcs_i (nfcs_i), .doe_i (doe_i), .read_i (read_i),
	.nslaven_o (nslaven_o), .ndtack_o (ndtack_o), .data_oe_o (data_oe_o)
);

`default_nettype wire

// File: tb_z3_slave.sv
// testbench for the Zorro III slave card: table-driven bus master with a reference memory
`default_nettype none

module tb_z3_slave;
	timeunit 1ns;
	timeprecision 100ps;

	import z3_bus_pkg::*;
	import z3_card_pkg::*;

	localparam int MEM_ADDR_W  = 8;
	localparam int ACK_DELAY   = 3;
	// clocks allowed for DTACK, and watched for silence on a miss
	localparam int CYC_TIMEOUT = 32;

	typedef enum logic [1:0] {CFG_RD, CFG_WR, MEM_RD, MEM_WR} cyc_kind_e;

	// one bus cycle of the table
	typedef struct packed {
		cyc_kind_e   kind;
		logic [31:0] addr;
		logic [1:0]  fc;
		logic [3:0]  nds;
		logic [31:0] wdata;
		logic        rnd;
		logic        resp;
		logic        ncfgout;
	} bus_row_t;

	logic        clk;
	logic        nIORST;
	logic        nfcs_i;
	logic        doe_i;
	logic        read_i;
	logic [1:0]  fc_i;
	logic [3:0]  nds_i;
	logic [23:0] ad_i;
	logic [5:0]  a_lo_i;
	logic [7:0]  sd_i;
	logic        ncfgin_i;
	logic        sensez3_i;
	logic [23:0] ad_o;
	logic [7:0]  sd_o;
	logic        data_oe_o;
	logic        nslaven_o;
	logic        ndtack_o;
	logic        ndtack_oe_o;
	logic        ncfgout_o;

	bus_row_t    rows[$];
	// word RAM as the host sees it, wraps on the RAM size
	logic [31:0] ref_mem [1 << MEM_ADDR_W];
	integer      seed;

	z3_slave_top #(.MEM_ADDR_W (MEM_ADDR_W), .ACK_DELAY (ACK_DELAY)) u_dut (
		.clk (clk), .nIORST (nIORST),
		.nfcs_i (nfcs_i), .doe_i (doe_i), .read_i (read_i), .fc_i (fc_i),
		.nds_i (nds_i), .ad_i (ad_i), .a_lo_i (a_lo_i), .sd_i (sd_i),
		.ncfgin_i (ncfgin_i), .sensez3_i (sensez3_i),
		.ad_o (ad_o), .sd_o (sd_o), .data_oe_o (data_oe_o), .nslaven_o (nslaven_o),
		.ndtack_o (ndtack_o), .ndtack_oe_o (ndtack_oe_o), .ncfgout_o (ncfgout_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	task automatic end_in_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got %h, expected %h", name, got, exp);
			end_in_failure();
		end
	endtask

	// register number sits on A8 and A4..A2
	function automatic logic [31:0] cfg_reg_addr(input logic [3:0] r);
		return {CFG_SPACE_HI, 7'd0, r[3], 3'd0, r[2:0], 2'b00};
	endfunction

	// rom nibble on D31..D28, all ones below
	function automatic logic [31:0] rom_word(input logic [31:0] a);
		return {cfg_rom[{a[8], a[4:2]}], 28'hFFF_FFFF};
	endfunction

	task automatic apply_reset();
		nIORST = 1'b0;
		repeat (4) @(negedge clk);
		nIORST = 1'b1;
	endtask

	task automatic add_row(input cyc_kind_e kind, input logic [31:0] addr,
			input logic [1:0] fc, input logic [3:0] nds, input logic [31:0] wdata,
			input logic rnd, input logic resp, input logic ncfgout);
		bus_row_t row;
		row.kind    = kind;
		row.addr    = addr;
		row.fc      = fc;
		row.nds     = nds;
		row.wdata   = wdata;
		row.rnd     = rnd;
		row.resp    = resp;
		row.ncfgout = ncfgout;
		rows.push_back(row);
	endtask

	// --------------------------------------------------
	// one full bus cycle, pins change on falling edges only
	task automatic run_cycle(input bus_row_t row);
		logic                  is_read;
		logic                  acked;
		int                    n;
		logic [31:0]           exp;
		logic [31:0]           got;
		logic [MEM_ADDR_W-1:0] idx;
		is_read = (row.kind == CFG_RD) || (row.kind == MEM_RD);
		idx     = row.addr[MEM_ADDR_W+1:2];
		// address phase
		@(negedge clk);
		ad_i   = row.addr[31:8];
		a_lo_i = row.addr[7:2];
		fc_i   = row.fc;
		read_i = is_read;
		nfcs_i = 1'b0;
		// data phase, write data in pin lane order
		@(negedge clk);
		check_value("nslaven_o", 32'(nslaven_o), 32'd1);
		doe_i = 1'b1;
		nds_i = row.nds;
		if (!is_read) begin
			ad_i = {row.wdata[31:24], row.wdata[15:0]};
			sd_i = row.wdata[23:16];
		end
		acked = 1'b0;
		n     = 0;
		while (!acked && n < CYC_TIMEOUT) begin
			@(negedge clk);
			// select one clock after the start edge
			if (row.resp && n == 0)
				check_value("nslaven_o", 32'(nslaven_o), 32'd0);
			if (!row.resp) begin
				check_value("nslaven_o", 32'(nslaven_o), 32'd1);
				check_value("data_oe_o", 32'(data_oe_o), 32'd0);
			end
			if (ndtack_o === 1'b0)
				acked = 1'b1;
			else
				n++;
		end
		if (row.resp && !acked) begin
			$display("timeout: no DTACK for the cycle at address %h", row.addr);
			end_in_failure();
		end
		if (!row.resp && acked) begin
			$display("DTACK came for the cycle at address %h, which must get no answer",
				row.addr);
			end_in_failure();
		end
		if (acked) begin
			// config data ready one clock after DOE is seen, then ACK_DELAY clocks
			if (row.kind == CFG_RD || row.kind == CFG_WR)
				check_value("ndtack_o delay", 32'(n), 32'(ACK_DELAY + 2));
			check_value("ndtack_oe_o", 32'(ndtack_oe_o), 32'd1);
			check_value("data_oe_o", 32'(data_oe_o), 32'(is_read));
			if (is_read) begin
				exp = (row.kind == CFG_RD) ? rom_word(row.addr) : ref_mem[idx];
				got = {ad_o[23:16], sd_o, ad_o[15:0]};
				check_value("ad_o:sd_o", got, exp);
			end else if (row.kind == MEM_WR) begin
				// merge bytes whose strobe is low
				for (int b = 0; b < 4; b++) begin
					if (!row.nds[b])
						ref_mem[idx][b*8 +: 8] = row.wdata[b*8 +: 8];
				end
			end
		end
		// master ends the cycle
		nfcs_i = 1'b1;
		doe_i  = 1'b0;
		nds_i  = 4'hF;
		n      = 0;
		while (nslaven_o !== 1'b1 && n < CYC_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (nslaven_o !== 1'b1) begin
			$display("timeout: nslaven_o stayed low after the cycle at %h", row.addr);
			end_in_failure();
		end
		check_value("ndtack_o", 32'(ndtack_o), 32'd1);
		// DTACK enable lingers one clock
		check_value("ndtack_oe_o", 32'(ndtack_oe_o), 32'(acked));
		@(negedge clk);
		check_value("ndtack_oe_o", 32'(ndtack_oe_o), 32'd0);
		check_value("ncfgout_o", 32'(ncfgout_o), 32'(row.ncfgout));
	endtask

	task automatic apply_table();
		bus_row_t row;
		foreach (rows[i]) begin
			row = rows[i];
			if (row.rnd)
				row.wdata = $random(seed);
			run_cycle(row);
		end
		rows.delete();
	endtask

	// --------------------------------------------------
	// kind, address, space, nDS, data, random, answered, nCFGOUT after
	task automatic build_main_table();
		add_row(CFG_RD, cfg_reg_addr(4'd0), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(CFG_RD, cfg_reg_addr(4'd5), FC_PROG, 4'h0, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(CFG_RD, cfg_reg_addr(4'd8), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(CFG_RD, cfg_reg_addr(4'd13), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b1);
		add_row(CFG_RD, cfg_reg_addr(4'd0), 2'b00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b1);
		// window placed at 0x4000_0000
		add_row(CFG_WR, cfg_reg_addr(REG_BASE), FC_DATA, 4'h0, 32'h4000_0000, 1'b0, 1'b1, 1'b0);
		add_row(CFG_RD, cfg_reg_addr(4'd0), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(CFG_WR, cfg_reg_addr(REG_SHUTUP), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(MEM_WR, 32'h4000_0000, FC_DATA, 4'h0, 32'h0, 1'b1, 1'b1, 1'b0);
		add_row(MEM_WR, 32'h4000_0004, FC_PROG, 4'h0, 32'h0, 1'b1, 1'b1, 1'b0);
		add_row(MEM_WR, 32'h4000_0010, FC_DATA, 4'h0, 32'h1122_3344, 1'b0, 1'b1, 1'b0);
		add_row(MEM_WR, 32'h4000_0000, FC_DATA, 4'b1100, 32'h0, 1'b1, 1'b1, 1'b0);
		add_row(MEM_WR, 32'h4000_0004, FC_DATA, 4'b0111, 32'h0, 1'b1, 1'b1, 1'b0);
		// same RAM word as 0x010
		add_row(MEM_WR, 32'h4000_0410, FC_DATA, 4'b1010, 32'hAABB_CCDD, 1'b0, 1'b1, 1'b0);
		add_row(MEM_RD, 32'h4000_0000, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
		add_row(MEM_RD, 32'h4000_0004, FC_PROG, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
		add_row(MEM_RD, 32'h4000_0010, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
		add_row(MEM_RD, 32'h4000_0410, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
		add_row(MEM_RD, 32'h43FF_FC04, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
		// outside the window, or cpu and reserved space
		add_row(MEM_WR, 32'h4400_0000, FC_DATA, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);
		add_row(MEM_RD, 32'h2000_0000, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(MEM_RD, 32'h4000_0000, 2'b00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(MEM_WR, 32'h4000_0000, 2'b11, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);
		add_row(MEM_RD, 32'h4000_0000, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
	endtask

	// zorro II backplane, nothing may answer
	task automatic build_zorro2_table();
		add_row(CFG_RD, cfg_reg_addr(4'd0), FC_DATA, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(CFG_WR, cfg_reg_addr(REG_BASE), FC_DATA, 4'h0, 32'h4000_0000, 1'b0, 1'b0, 1'b0);
		add_row(MEM_RD, 32'h4000_0000, FC_DATA, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		add_row(MEM_WR, 32'h4000_0000, FC_DATA, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);
	endtask

	// --------------------------------------------------
	initial begin
		seed      = 32'h87bca4ee;
		nIORST    = 1'b0;
		nfcs_i    = 1'b1;
		doe_i     = 1'b0;
		read_i    = 1'b1;
		fc_i      = FC_DATA;
		nds_i     = 4'hF;
		ad_i      = '0;
		a_lo_i    = '0;
		sd_i      = '0;
		ncfgin_i  = 1'b0;
		sensez3_i = 1'b1;
		apply_reset();
		@(negedge clk);
		check_value("nslaven_o", 32'(nslaven_o), 32'd1);
		check_value("ndtack_o", 32'(ndtack_o), 32'd1);
		check_value("ncfgout_o", 32'(ncfgout_o), 32'd1);
		check_value("data_oe_o", 32'(data_oe_o), 32'd0);
		check_value("ndtack_oe_o", 32'(ndtack_oe_o), 32'd0);
		build_main_table();
		apply_table();
		// second run on a zorro II backplane
		sensez3_i = 1'b0;
		ncfgin_i  = 1'b1;
		apply_reset();
		@(negedge clk);
		check_value("nslaven_o", 32'(nslaven_o), 32'd1);
		check_value("ndtack_o", 32'(ndtack_o), 32'd1);
		check_value("data_oe_o", 32'(data_oe_o), 32'd0);
		// chain passes straight through, ends with config-in low
		for (int k = 0; k < 4; k++) begin
			ncfgin_i = (k % 2 == 0);
			@(negedge clk);
			check_value("ncfgout_o", 32'(ncfgout_o), 32'(ncfgin_i));
		end
		build_zorro2_table();
		apply_table();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
z3_bus_pkg.sv
z3_card_pkg.sv
z3_bus_frontend.sv
z3_cycle_fsm.sv
z3_autoconfig.sv
z3_mem_window.sv
z3_slave_top.sv
tb_z3_slave_assertions.sv
tb_z3_slave.sv

// File: Makefile
# Verilator build and run for the Zorro III slave testbench

VERILATOR ?= verilator
TOP       ?= tb_z3_slave
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
